/* common/ex_macros.svh */
/*
 * width and stall level definitions for the execute stage
 * data, memory address and register index widths
 */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// register and memory data width.
`define XLEN_W		64

`define ADDR_MEM_W	64
`define ADDR_REG_W	5

// matches HOLD_EX in hold_code_e.
`define HOLD_LVL_EX	3'd3

`endif

/* common/ex_pkg.sv */
/*
 * execute stage types
 * alu operation, load code, store code and hold code enumerations
 */
package ex_pkg;

	// funct3 ordering of the rv base integer ops.
	typedef enum logic [3:0] {
		ADD		= 4'd0,	// sub with alu_add_sub.
		SLL		= 4'd1,
		SLT		= 4'd2,
		SLTU	= 4'd3,
		XOR		= 4'd4,
		SRL		= 4'd5,	// sra with alu_shift.
		OR		= 4'd6,
		AND		= 4'd7
	} alu_op_e;

	typedef enum logic [2:0] {
		L_NONE	= 3'd0,
		LB		= 3'd1,
		LH		= 3'd2,
		LW		= 3'd3,
		LD		= 3'd4,
		LBU		= 3'd5,
		LHU		= 3'd6,
		LWU		= 3'd7
	} load_code_e;

	typedef enum logic [2:0] {
		S_NONE	= 3'd0,
		SB		= 3'd1,
		SH		= 3'd2,
		SW		= 3'd3,
		SD		= 3'd4
	} store_code_e;

	// stall source, deeper stages have higher codes.
	typedef enum logic [2:0] {
		HOLD_NONE	= 3'd0,
		HOLD_IF		= 3'd1,
		HOLD_ID		= 3'd2,
		HOLD_EX		= 3'd3,
		HOLD_MEM	= 3'd4
	} hold_code_e;

endpackage

/* ex_stage/ex_operand_latch.sv */
/*
 * id/ex pipeline register
 * holds on stall, resets to a bubble
 */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_operand_latch
	import ex_pkg::*;
(
	input	logic						clk,
	input	logic						arst_n_i,
	input	logic						hold_i,

	input	logic [`ADDR_MEM_W-1:0]		pc_i,
	input	logic [`XLEN_W-1:0]			data_rs1_i,
	input	logic [`XLEN_W-1:0]			data_rs2_i,
	input	alu_op_e					alu_operation_i,
	input	logic						alu_add_sub_i,
	input	logic						alu_shift_i,
	input	logic						word_intercept_i,
	input	logic [`XLEN_W-1:0]			alu_op_num1_i,
	input	logic [`XLEN_W-1:0]			alu_op_num2_i,
	input	load_code_e					load_code_i,
	input	store_code_e				store_code_i,
	input	logic [`ADDR_REG_W-1:0]		addr_reg_wr_i,
	input	logic						reg_wr_en_i,

	output	logic [`ADDR_MEM_W-1:0]		pc_o,
	output	logic [`XLEN_W-1:0]			data_rs1_o,
	output	logic [`XLEN_W-1:0]			data_rs2_o,
	output	alu_op_e					alu_operation_o,
	output	logic						alu_add_sub_o,
	output	logic						alu_shift_o,
	output	logic						word_intercept_o,
	output	logic [`XLEN_W-1:0]			alu_op_num1_o,
	output	logic [`XLEN_W-1:0]			alu_op_num2_o,
	output	load_code_e					load_code_o,
	output	store_code_e				store_code_o,
	output	logic [`ADDR_REG_W-1:0]		addr_reg_wr_o,
	output	logic						reg_wr_en_o
);

	// bubble on reset: no write-back, no memory access.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			load_code_o <= L_NONE;
			store_code_o <= S_NONE;
			reg_wr_en_o <= 1'b0;
		end else if (!hold_i) begin
			load_code_o <= load_code_i;
			store_code_o <= store_code_i;
			reg_wr_en_o <= reg_wr_en_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold_i) begin
			pc_o <= pc_i;
			data_rs1_o <= data_rs1_i;
			data_rs2_o <= data_rs2_i;
			alu_operation_o <= alu_operation_i;
			alu_add_sub_o <= alu_add_sub_i;
			alu_shift_o <= alu_shift_i;
			word_intercept_o <= word_intercept_i;
			alu_op_num1_o <= alu_op_num1_i;
			alu_op_num2_o <= alu_op_num2_i;
			addr_reg_wr_o <= addr_reg_wr_i;
		end
	end

	// decode never issues a load and a store as one instruction.
	ast_ld_st_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
		(load_code_o != L_NONE) |-> (store_code_o == S_NONE))
		else $error("latched load and store together");

endmodule

/* ex_stage/ex_alu.sv */
/*
 * combinational alu with word intercept
 * load/store address generation, store data shaping, memory enables
 */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_alu
	import ex_pkg::*;
(
	input	logic						clk,
	input	logic						arst_n_i,

	input	logic [`ADDR_MEM_W-1:0]		pc_i,
	input	logic [`XLEN_W-1:0]			data_rs1_i,
	input	logic [`XLEN_W-1:0]			data_rs2_i,
	input	alu_op_e					alu_operation_i,
	input	logic						alu_add_sub_i,
	input	logic						alu_shift_i,
	input	logic						word_intercept_i,
	input	logic [`XLEN_W-1:0]			alu_op_num1_i,
	input	logic [`XLEN_W-1:0]			alu_op_num2_i,
	input	load_code_e					load_code_i,
	input	store_code_e				store_code_i,

	output	logic [`XLEN_W-1:0]			alu_result_o,
	output	logic						mem_rd_en_o,
	output	logic						mem_wr_en_o,
	output	logic [`ADDR_MEM_W-1:0]		addr_mem_rd_o,
	output	logic [`ADDR_MEM_W-1:0]		addr_mem_wr_o,
	output	logic [`XLEN_W-1:0]			data_mem_wr_o
);

	localparam int SHAMT_W = $clog2(`XLEN_W);

	logic [SHAMT_W-1:0]		shamt;
	logic [`XLEN_W-1:0]		shift_src;
	logic [`XLEN_W-1:0]		sum;
	logic [`XLEN_W-1:0]		srl_val;
	logic signed [`XLEN_W-1:0]	sra_val;
	logic [`XLEN_W-1:0]		raw_result;
	logic [`XLEN_W-1:0]		addr_sum;
	logic [`ADDR_MEM_W-1:0]	mem_addr;

	// word ops shift by five bits only.
	assign shamt = word_intercept_i ? SHAMT_W'(alu_op_num2_i[4:0]) : alu_op_num2_i[SHAMT_W-1:0];

	// right shifts of a word see only the low half, extended by shift kind.
	always_comb begin
		if (!word_intercept_i)
			shift_src = alu_op_num1_i;
		else if (alu_shift_i)
			shift_src = {{(`XLEN_W-32){alu_op_num1_i[31]}}, alu_op_num1_i[31:0]};
		else
			shift_src = {{(`XLEN_W-32){1'b0}}, alu_op_num1_i[31:0]};
	end

	assign sum = alu_add_sub_i ? (alu_op_num1_i - alu_op_num2_i) : (alu_op_num1_i + alu_op_num2_i);
	assign srl_val = shift_src >> shamt;
	assign sra_val = $signed(shift_src) >>> shamt;

	always_comb begin
		case (alu_operation_i)
			ADD:	raw_result = sum;
			SLL:	raw_result = alu_op_num1_i << shamt;
			SLT:	raw_result = {{(`XLEN_W-1){1'b0}}, $signed(alu_op_num1_i) < $signed(alu_op_num2_i)};
			SLTU:	raw_result = {{(`XLEN_W-1){1'b0}}, alu_op_num1_i < alu_op_num2_i};
			XOR:	raw_result = alu_op_num1_i ^ alu_op_num2_i;
			SRL:	raw_result = alu_shift_i ? sra_val : srl_val;
			OR:		raw_result = alu_op_num1_i | alu_op_num2_i;
			AND:	raw_result = alu_op_num1_i & alu_op_num2_i;
			default: raw_result = '0;
		endcase
	end

	assign alu_result_o = word_intercept_i ?
		{{(`XLEN_W-32){raw_result[31]}}, raw_result[31:0]} : raw_result;

	// effective address, never subtracted.
	assign addr_sum = alu_op_num1_i + alu_op_num2_i;
	assign mem_addr = addr_sum[`ADDR_MEM_W-1:0];

	assign mem_rd_en_o = (load_code_i != L_NONE);
	assign mem_wr_en_o = (store_code_i != S_NONE);
	assign addr_mem_rd_o = mem_rd_en_o ? mem_addr : '0;
	assign addr_mem_wr_o = mem_wr_en_o ? mem_addr : '0;

	always_comb begin
		case (store_code_i)
			SB:		data_mem_wr_o = {{(`XLEN_W-8){1'b0}}, data_rs2_i[7:0]};
			SH:		data_mem_wr_o = {{(`XLEN_W-16){1'b0}}, data_rs2_i[15:0]};
			SW:		data_mem_wr_o = {{(`XLEN_W-32){1'b0}}, data_rs2_i[31:0]};
			SD:		data_mem_wr_o = data_rs2_i;
			default: data_mem_wr_o = '0;	// no store.
		endcase
	end

	ast_mem_en_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
		!(mem_rd_en_o && mem_wr_en_o))
		else $error("memory read and write enables both high");

	// decode routes rs1 as the base of every access.
	ast_mem_base: assert property (@(posedge clk) disable iff (!arst_n_i)
		(mem_rd_en_o || mem_wr_en_o) |-> (alu_op_num1_i == data_rs1_i))
		else $error("memory base is not rs1");

	ast_pc_align: assert property (@(posedge clk) disable iff (!arst_n_i)
		pc_i[1:0] == 2'b00)
		else $error("misaligned pc in execute");

endmodule

/* ex_stage/ex_mem_reg.sv */
/*
 * ex/mem pipeline register
 * load data extension and write-back select
 */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_mem_reg
	import ex_pkg::*;
(
	input	logic						clk,
	input	logic						arst_n_i,
	input	logic						hold_i,

	input	logic [`XLEN_W-1:0]			data_mem_i,
	input	logic [`XLEN_W-1:0]			data_alu_i,
	input	load_code_e					load_code_i,
	input	logic [`ADDR_REG_W-1:0]		addr_reg_wr_i,
	input	logic						reg_wr_en_i,

	output	logic [`XLEN_W-1:0]			data_reg_wr_o,
	output	logic [`ADDR_REG_W-1:0]		addr_reg_wr_o,
	output	logic						reg_wr_en_o
);

	logic [`XLEN_W-1:0] wb_data;

	// low bytes of the returned word, extended per load code.
	always_comb begin
		case (load_code_i)
			LB:		wb_data = {{(`XLEN_W-8){data_mem_i[7]}}, data_mem_i[7:0]};
			LH:		wb_data = {{(`XLEN_W-16){data_mem_i[15]}}, data_mem_i[15:0]};
			LW:		wb_data = {{(`XLEN_W-32){data_mem_i[31]}}, data_mem_i[31:0]};
			LD:		wb_data = data_mem_i;
			LBU:	wb_data = {{(`XLEN_W-8){1'b0}}, data_mem_i[7:0]};
			LHU:	wb_data = {{(`XLEN_W-16){1'b0}}, data_mem_i[15:0]};
			LWU:	wb_data = {{(`XLEN_W-32){1'b0}}, data_mem_i[31:0]};
			default: wb_data = data_alu_i;	// not a load.
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			reg_wr_en_o <= 1'b0;
		else if (!hold_i)
			reg_wr_en_o <= reg_wr_en_i;
	end

	always_ff @(posedge clk) begin
		if (!hold_i) begin
			data_reg_wr_o <= wb_data;
			addr_reg_wr_o <= addr_reg_wr_i;
		end
	end

	// decode drops loads that target x0.
	ast_no_ld_x0: assert property (@(posedge clk) disable iff (!arst_n_i)
		($rose(reg_wr_en_o) && addr_reg_wr_o == '0) |-> ($past(load_code_i) == L_NONE))
		else $error("load write-back to x0");

endmodule

/* hdl/ex_top.sv */
/*
 * execute stage top
 * id/ex latch, alu and ex/mem register under one hold level
 */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_top
	import ex_pkg::*;
(
	input	logic						clk,
	input	logic						arst_n_i,

	input	hold_code_e					hold_code_i,

	input	logic [`ADDR_MEM_W-1:0]		pc_i,
	input	logic [`XLEN_W-1:0]			data_rs1_i,
	input	logic [`XLEN_W-1:0]			data_rs2_i,
	input	alu_op_e					alu_operation_i,
	input	logic						alu_add_sub_i,
	input	logic						alu_shift_i,
	input	logic						word_intercept_i,
	input	logic [`XLEN_W-1:0]			alu_op_num1_i,
	input	logic [`XLEN_W-1:0]			alu_op_num2_i,
	input	load_code_e					load_code_i,
	input	store_code_e				store_code_i,
	input	logic [`ADDR_REG_W-1:0]		addr_reg_wr_i,
	input	logic						reg_wr_en_i,
	input	logic [`XLEN_W-1:0]			data_mem_i,

	output	logic [`XLEN_W-1:0]			alu_result_o,
	output	logic						mem_rd_en_o,
	output	logic						mem_wr_en_o,
	output	logic [`ADDR_MEM_W-1:0]		addr_mem_rd_o,
	output	logic [`ADDR_MEM_W-1:0]		addr_mem_wr_o,
	output	logic [`XLEN_W-1:0]			data_mem_wr_o,
	output	logic [`XLEN_W-1:0]			data_reg_wr_o,
	output	logic [`ADDR_REG_W-1:0]		addr_reg_wr_o,
	output	logic						reg_wr_en_o
);

	logic						hold;
	logic [`ADDR_MEM_W-1:0]		ex_pc;
	logic [`XLEN_W-1:0]			ex_rs1;
	logic [`XLEN_W-1:0]			ex_rs2;
	alu_op_e					ex_alu_op;
	logic						ex_add_sub;
	logic						ex_shift;
	logic						ex_word;
	logic [`XLEN_W-1:0]			ex_num1;
	logic [`XLEN_W-1:0]			ex_num2;
	load_code_e					ex_load_code;
	store_code_e				ex_store_code;
	logic [`ADDR_REG_W-1:0]		ex_addr_reg_wr;
	logic						ex_reg_wr_en;

	// stall this stage and everything behind it.
	assign hold = (hold_code_i >= `HOLD_LVL_EX);

	ex_operand_latch ex_operand_latch_inst (
		.clk				(clk),
		.arst_n_i			(arst_n_i),
		.hold_i				(hold),
		.pc_i				(pc_i),
		.data_rs1_i			(data_rs1_i),
		.data_rs2_i			(data_rs2_i),
		.alu_operation_i	(alu_operation_i),
		.alu_add_sub_i		(alu_add_sub_i),
		.alu_shift_i		(alu_shift_i),
		.word_intercept_i	(word_intercept_i),
		.alu_op_num1_i		(alu_op_num1_i),
		.alu_op_num2_i		(alu_op_num2_i),
		.load_code_i		(load_code_i),
		.store_code_i		(store_code_i),
		.addr_reg_wr_i		(addr_reg_wr_i),
		.reg_wr_en_i		(reg_wr_en_i),
		.pc_o				(ex_pc),
		.data_rs1_o			(ex_rs1),
		.data_rs2_o			(ex_rs2),
		.alu_operation_o	(ex_alu_op),
		.alu_add_sub_o		(ex_add_sub),
		.alu_shift_o		(ex_shift),
		.word_intercept_o	(ex_word),
		.alu_op_num1_o		(ex_num1),
		.alu_op_num2_o		(ex_num2),
		.load_code_o		(ex_load_code),
		.store_code_o		(ex_store_code),
		.addr_reg_wr_o		(ex_addr_reg_wr),
		.reg_wr_en_o		(ex_reg_wr_en)
	);

	ex_alu ex_alu_inst (
		.clk				(clk),
		.arst_n_i			(arst_n_i),
		.pc_i				(ex_pc),
		.data_rs1_i			(ex_rs1),
		.data_rs2_i			(ex_rs2),
		.alu_operation_i	(ex_alu_op),
		.alu_add_sub_i		(ex_add_sub),
		.alu_shift_i		(ex_shift),
		.word_intercept_i	(ex_word),
		.alu_op_num1_i		(ex_num1),
		.alu_op_num2_i		(ex_num2),
		.load_code_i		(ex_load_code),
		.store_code_i		(ex_store_code),
		.alu_result_o		(alu_result_o),
		.mem_rd_en_o		(mem_rd_en_o),
		.mem_wr_en_o		(mem_wr_en_o),
		.addr_mem_rd_o		(addr_mem_rd_o),
		.addr_mem_wr_o		(addr_mem_wr_o),
		.data_mem_wr_o		(data_mem_wr_o)
	);

	// memory answers in the same cycle as the read enable.
	ex_mem_reg ex_mem_reg_inst (
		.clk				(clk),
		.arst_n_i			(arst_n_i),
		.hold_i				(hold),
		.data_mem_i			(data_mem_i),
		.data_alu_i			(alu_result_o),
		.load_code_i		(ex_load_code),
		.addr_reg_wr_i		(ex_addr_reg_wr),
		.reg_wr_en_i		(ex_reg_wr_en),
		.data_reg_wr_o		(data_reg_wr_o),
		.addr_reg_wr_o		(addr_reg_wr_o),
		.reg_wr_en_o		(reg_wr_en_o)
	);

endmodule

/* tb/ex_checker.sv */
/*
 * execute stage checker
 * two-entry reference pipeline, port compares, closing error count
 */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_checker
	import ex_pkg::*;
(
	input	logic						clk,
	input	logic						arst_n_i,
	input	logic						done_i,
	input	hold_code_e					hold_code_i,
	input	logic [`XLEN_W-1:0]			data_rs2_i,
	input	alu_op_e					alu_operation_i,
	input	logic						alu_add_sub_i,
	input	logic						alu_shift_i,
	input	logic						word_intercept_i,
	input	logic [`XLEN_W-1:0]			alu_op_num1_i,
	input	logic [`XLEN_W-1:0]			alu_op_num2_i,
	input	load_code_e					load_code_i,
	input	store_code_e				store_code_i,
	input	logic [`ADDR_REG_W-1:0]		addr_reg_wr_i,
	input	logic						reg_wr_en_i,
	input	logic [`XLEN_W-1:0]			dut_alu_result_i,
	input	logic						dut_mem_rd_en_i,
	input	logic						dut_mem_wr_en_i,
	input	logic [`ADDR_MEM_W-1:0]		dut_addr_mem_rd_i,
	input	logic [`ADDR_MEM_W-1:0]		dut_addr_mem_wr_i,
	input	logic [`XLEN_W-1:0]			dut_data_mem_wr_i,
	input	logic [`XLEN_W-1:0]			dut_data_reg_wr_i,
	input	logic [`ADDR_REG_W-1:0]		dut_addr_reg_wr_i,
	input	logic						dut_reg_wr_en_i,
	output	int							error_count_o
);

	int checks = 0;
	int errors = 0;

	// execute slot of the model.
	alu_op_e lat_op = ADD;
	logic lat_sub = 1'b0;
	logic lat_sra = 1'b0;
	logic lat_word = 1'b0;
	logic [`XLEN_W-1:0] lat_num1 = '0;
	logic [`XLEN_W-1:0] lat_num2 = '0;
	logic [`XLEN_W-1:0] lat_rs2 = '0;
	load_code_e lat_load = L_NONE;
	store_code_e lat_store = S_NONE;
	logic [`ADDR_REG_W-1:0] lat_rd = '0;
	logic lat_wen = 1'b0;

	// write-back slot of the model.
	logic m_wen = 1'b0;
	logic [`ADDR_REG_W-1:0] m_rd = '0;
	logic [`XLEN_W-1:0] m_data = '0;

	assign error_count_o = errors;

	function automatic logic [7:0] mem_byte(input int idx);
		return 8'(idx * 37) ^ 8'(idx >> 2) ^ 8'h5a;	// same fill as the memory model.
	endfunction

	// little endian word that wraps inside the 1 KiB window.
	function automatic logic [`XLEN_W-1:0] mem_word(input logic [`ADDR_MEM_W-1:0] addr);
		logic [`XLEN_W-1:0] w;
		for (int k = 0; k < 8; k++)
			w[8*k +: 8] = mem_byte((int'(addr[9:0]) + k) % 1024);
		return w;
	endfunction

	function automatic logic [`XLEN_W-1:0] alu_model(input alu_op_e op, input logic sub,
		input logic sra, input logic word, input logic [`XLEN_W-1:0] a,
		input logic [`XLEN_W-1:0] b);
		logic [5:0] sh;
		logic [31:0] lo;
		logic [`XLEN_W-1:0] r;
		sh = word ? {1'b0, b[4:0]} : b[5:0];
		case (op)
			ADD:	r = sub ? a - b : a + b;
			SLL:	r = a << sh;
			SLT:	r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			SLTU:	r = (a < b) ? 64'd1 : 64'd0;
			XOR:	r = a ^ b;
			OR:		r = a | b;
			AND:	r = a & b;
			default: begin
				// right shifts of a word work on the low 32 bits.
				if (word) begin
					if (sra)
						lo = $signed(a[31:0]) >>> sh;
					else
						lo = a[31:0] >> sh;
					r = {32'd0, lo};
				end else if (sra) begin
					r = $signed(a) >>> sh;
				end else begin
					r = a >> sh;
				end
			end
		endcase
		if (word)
			r = {{32{r[31]}}, r[31:0]};
		return r;
	endfunction

	function automatic logic [`XLEN_W-1:0] load_extend(input load_code_e code,
		input logic [`XLEN_W-1:0] w);
		case (code)
			LB:		return {{56{w[7]}}, w[7:0]};
			LH:		return {{48{w[15]}}, w[15:0]};
			LW:		return {{32{w[31]}}, w[31:0]};
			LBU:	return {56'd0, w[7:0]};
			LHU:	return {48'd0, w[15:0]};
			LWU:	return {32'd0, w[31:0]};
			default: return w;
		endcase
	endfunction

	function automatic logic [`XLEN_W-1:0] store_mask(input store_code_e code,
		input logic [`XLEN_W-1:0] d);
		case (code)
			SB:		return {56'd0, d[7:0]};
			SH:		return {48'd0, d[15:0]};
			SW:		return {32'd0, d[31:0]};
			default: return d;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [`XLEN_W-1:0] exp,
		input logic [`XLEN_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error: time %0t, %s expected %h, actual %h", $time, name, exp, act);
		end
	endtask

	task automatic take_inputs();
		lat_op = alu_operation_i;
		lat_sub = alu_add_sub_i;
		lat_sra = alu_shift_i;
		lat_word = word_intercept_i;
		lat_num1 = alu_op_num1_i;
		lat_num2 = alu_op_num2_i;
		lat_rs2 = data_rs2_i;
		lat_rd = addr_reg_wr_i;
	endtask

	// compare mid-cycle and step the model as the next edge will.
	always @(negedge clk) begin
		if (!arst_n_i) begin
			take_inputs();
			lat_load = L_NONE;	// bubble.
			lat_store = S_NONE;
			lat_wen = 1'b0;
			m_wen = 1'b0;
		end else if (!done_i) begin
			check_value("alu_result_o", alu_model(lat_op, lat_sub, lat_sra, lat_word,
				lat_num1, lat_num2), dut_alu_result_i);
			check_value("mem_rd_en_o", 64'(lat_load != L_NONE), 64'(dut_mem_rd_en_i));
			check_value("mem_wr_en_o", 64'(lat_store != S_NONE), 64'(dut_mem_wr_en_i));
			if (lat_load != L_NONE)
				check_value("addr_mem_rd_o", lat_num1 + lat_num2, dut_addr_mem_rd_i);
			if (lat_store != S_NONE) begin
				check_value("addr_mem_wr_o", lat_num1 + lat_num2, dut_addr_mem_wr_i);
				check_value("data_mem_wr_o", store_mask(lat_store, lat_rs2), dut_data_mem_wr_i);
			end
			if (dut_mem_rd_en_i && dut_mem_wr_en_i) begin
				errors++;
				$display("** Error: time %0t, memory read and write enabled together", $time);
			end
			check_value("reg_wr_en_o", 64'(m_wen), 64'(dut_reg_wr_en_i));
			if (m_wen) begin
				check_value("addr_reg_wr_o", 64'(m_rd), 64'(dut_addr_reg_wr_i));
				check_value("data_reg_wr_o", m_data, dut_data_reg_wr_i);
			end
			if (hold_code_i < HOLD_EX) begin
				m_wen = lat_wen;
				m_rd = lat_rd;
				if (lat_load != L_NONE)
					m_data = load_extend(lat_load, mem_word(lat_num1 + lat_num2));
				else
					m_data = alu_model(lat_op, lat_sub, lat_sra, lat_word, lat_num1, lat_num2);
				take_inputs();
				lat_load = load_code_i;
				lat_store = store_code_i;
				lat_wen = reg_wr_en_i;
			end
		end
	end

	always @(posedge done_i)
		$display("checker: %0d checks, %0d errors", checks, errors);

endmodule

/* tb/tb_ex_top.sv */
/*
 * execute stage testbench
 * clock, reset, seeded random instruction stream, memory model, watchdog
 */
`timescale 1ns/1ps
`include "ex_macros.svh"

module tb_ex_top
	import ex_pkg::*;
;

	localparam int CLK_PERIOD = 4;
	localparam int N_INSTR = 2000;
	localparam int WATCHDOG_NS = CLK_PERIOD * N_INSTR * 3;

	logic clk;
	logic arst_n_i;
	hold_code_e hold_code_i;
	logic [`ADDR_MEM_W-1:0] pc_i;
	logic [`XLEN_W-1:0] data_rs1_i;
	logic [`XLEN_W-1:0] data_rs2_i;
	alu_op_e alu_operation_i;
	logic alu_add_sub_i;
	logic alu_shift_i;
	logic word_intercept_i;
	logic [`XLEN_W-1:0] alu_op_num1_i;
	logic [`XLEN_W-1:0] alu_op_num2_i;
	load_code_e load_code_i;
	store_code_e store_code_i;
	logic [`ADDR_REG_W-1:0] addr_reg_wr_i;
	logic reg_wr_en_i;
	logic [`XLEN_W-1:0] data_mem_i;
	logic [`XLEN_W-1:0] alu_result_o;
	logic mem_rd_en_o;
	logic mem_wr_en_o;
	logic [`ADDR_MEM_W-1:0] addr_mem_rd_o;
	logic [`ADDR_MEM_W-1:0] addr_mem_wr_o;
	logic [`XLEN_W-1:0] data_mem_wr_o;
	logic [`XLEN_W-1:0] data_reg_wr_o;
	logic [`ADDR_REG_W-1:0] addr_reg_wr_o;
	logic reg_wr_en_o;
	logic run_done;
	int error_count;
	logic [7:0] mem [1024];

	ex_top ex_top_inst (.*);

	ex_checker ex_checker_inst (
		.*,
		.done_i				(run_done),
		.dut_alu_result_i	(alu_result_o),
		.dut_mem_rd_en_i	(mem_rd_en_o),
		.dut_mem_wr_en_i	(mem_wr_en_o),
		.dut_addr_mem_rd_i	(addr_mem_rd_o),
		.dut_addr_mem_wr_i	(addr_mem_wr_o),
		.dut_data_mem_wr_i	(data_mem_wr_o),
		.dut_data_reg_wr_i	(data_reg_wr_o),
		.dut_addr_reg_wr_i	(addr_reg_wr_o),
		.dut_reg_wr_en_i	(reg_wr_en_o),
		.error_count_o		(error_count)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// 1 KiB window answered in the same cycle, little endian.
	always_comb begin
		data_mem_i = '0;
		if (mem_rd_en_o)
			for (int k = 0; k < 8; k++)
				data_mem_i[8*k +: 8] = mem[10'(addr_mem_rd_o[9:0] + 10'(k))];
	end

	task automatic drive_instr();
		logic [`XLEN_W-1:0] base;
		int kind;
		kind = $urandom_range(0, 9);
		base = {$urandom, $urandom};
		pc_i <= pc_i + 64'd4;
		data_rs2_i <= {$urandom, $urandom};
		alu_operation_i <= alu_op_e'(4'($urandom_range(0, 7)));
		alu_add_sub_i <= 1'($urandom_range(0, 1));
		alu_shift_i <= 1'($urandom_range(0, 1));
		word_intercept_i <= 1'($urandom_range(0, 1));
		if (kind < 2) begin
			base = 64'($urandom_range(0, 511));	// keep loads inside the window.
			data_rs1_i <= base;
			alu_op_num1_i <= base;
			alu_op_num2_i <= 64'($urandom_range(0, 511));
			load_code_i <= load_code_e'(3'($urandom_range(1, 7)));
			store_code_i <= S_NONE;
			addr_reg_wr_i <= 5'($urandom_range(1, 31));
			reg_wr_en_i <= 1'b1;
		end else begin
			data_rs1_i <= base;
			alu_op_num1_i <= (kind < 4) ? base : {$urandom, $urandom};
			alu_op_num2_i <= {$urandom, $urandom};
			load_code_i <= L_NONE;
			store_code_i <= (kind < 4) ? store_code_e'(3'($urandom_range(1, 4))) : S_NONE;
			addr_reg_wr_i <= 5'($urandom_range(0, 31));
			reg_wr_en_i <= 1'($urandom_range(0, 1));
		end
	endtask

	initial begin
		int issued;
		int hold_pick;
		issued = 0;
		void'($urandom(32'h4b12));
		for (int i = 0; i < 1024; i++)
			mem[i] = 8'(i * 37) ^ 8'(i >> 2) ^ 8'h5a;	// mixes all ten address bits.
		arst_n_i = 1'b0;
		run_done = 1'b0;
		hold_code_i = HOLD_NONE;
		pc_i = '0;
		data_rs1_i = '0;
		data_rs2_i = '0;
		alu_operation_i = ADD;
		alu_add_sub_i = 1'b0;
		alu_shift_i = 1'b0;
		word_intercept_i = 1'b0;
		alu_op_num1_i = '0;
		alu_op_num2_i = '0;
		load_code_i = L_NONE;
		store_code_i = S_NONE;
		addr_reg_wr_i = '0;
		reg_wr_en_i = 1'b0;
		repeat (2) @(posedge clk);
		arst_n_i <= 1'b1;
		while (issued < N_INSTR) begin
			@(posedge clk);
			drive_instr();
			hold_pick = $urandom_range(0, 99);
			if (hold_pick < 20) begin
				hold_code_i <= ($urandom_range(0, 1) != 0) ? HOLD_EX : HOLD_MEM;
			end else begin
				hold_code_i <= hold_code_e'(3'($urandom_range(0, 2)));
				issued++;
			end
		end
		// drain the two stages with bubbles.
		@(posedge clk);
		load_code_i <= L_NONE;
		store_code_i <= S_NONE;
		reg_wr_en_i <= 1'b0;
		hold_code_i <= HOLD_NONE;
		repeat (3) @(posedge clk);
		run_done <= 1'b1;
		repeat (2) @(posedge clk);
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: instruction stream did not finish within %0d ns", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* project.f */
+incdir+common
common/ex_pkg.sv
ex_stage/ex_operand_latch.sv
ex_stage/ex_alu.sv
ex_stage/ex_mem_reg.sv
hdl/ex_top.sv
tb/ex_checker.sv
tb/tb_ex_top.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the execute stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f project.f --top-module tb_ex_top -Mdir obj_dir -o sim_ex_top

# the log decides pass or fail
./obj_dir/sim_ex_top > sim.log 2>&1 || true
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1
